/* Makefile */
# Verilator build and run of the message to AXI4-Lite bridge testbench
VERILATOR ?= verilator
TOP       ?= tb_bp_axil_lite_top
OBJ_DIR   ?= obj_dir
FLIST     ?= list.f
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* bp_axil_consts.svh */
// Field widths shared by the BedRock message ports and the AXI4-Lite masters
`ifndef BP_AXIL_CONSTS_SVH
`define BP_AXIL_CONSTS_SVH

// AXI4-Lite address and data paths
`define BP_AXIL_ADDR_W 32
`define BP_AXIL_DATA_W 64
`define BP_AXIL_STRB_W 8

// Byte lane offset inside one data word
`define BP_AXIL_OFFS_W 3

// AXI4-Lite protection and response codes
`define BP_AXIL_PROT_W 3
`define BP_AXIL_RESP_W 2

// BedRock message header fields
`define BP_MSG_TYPE_W 1
`define BP_MSG_SIZE_W 2
`define BP_MSG_TAG_W 8

`endif

/* bp_axil_ctrl.sv */
// Channel sequencer for the message to AXI4-Lite bridge
// Accepts one command, runs the AXI phases and returns one response
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module bp_axil_ctrl
  (input  wire                          clk_i
  ,input  wire                          arst_n_i

  ,input  wire                          io_cmd_v_i
  ,output logic                         io_cmd_ready_and_o
  ,input  wire bp_bedrock_pkg::bp_msg_type_e cmd_type_i

  ,output logic                         awvalid_o
  ,input  wire                          awready_i
  ,output logic                         wvalid_o
  ,input  wire                          wready_i
  ,input  wire                          bvalid_i
  ,output logic                         bready_o
  ,output logic                         arvalid_o
  ,input  wire                          arready_i
  ,input  wire                          rvalid_i
  ,output logic                         rready_o

  ,output logic                         io_resp_v_o
  ,input  wire                          io_resp_ready_and_i

  ,output logic                         cmd_load_o
  ,output logic                         rdata_load_o
  );

  import bp_bedrock_pkg::*;

  typedef enum logic [2:0]
  {
    e_idle,
    e_wr_addr,
    e_wr_resp,
    e_rd_addr,
    e_rd_data,
    e_resp
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   aw_done_r;
  logic   w_done_r;
  logic   aw_hs;
  logic   w_hs;

  assign io_cmd_ready_and_o = (state_r == e_idle);
  assign awvalid_o          = (state_r == e_wr_addr) & ~aw_done_r;
  assign wvalid_o           = (state_r == e_wr_addr) & ~w_done_r;
  assign bready_o           = (state_r == e_wr_resp);
  assign arvalid_o          = (state_r == e_rd_addr);
  assign rready_o           = (state_r == e_rd_data);
  assign io_resp_v_o        = (state_r == e_resp);

  assign cmd_load_o   = io_cmd_ready_and_o & io_cmd_v_i;
  assign rdata_load_o = rready_o & rvalid_i;
  assign aw_hs        = awvalid_o & awready_i;
  assign w_hs         = wvalid_o & wready_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:    if (io_cmd_v_i) state_n = (cmd_type_i == e_mem_uc_wr) ? e_wr_addr : e_rd_addr;
      e_wr_addr: if ((aw_done_r | aw_hs) & (w_done_r | w_hs)) state_n = e_wr_resp;
      e_wr_resp: if (bvalid_i) state_n = e_resp;
      e_rd_addr: if (arready_i) state_n = e_rd_data;
      e_rd_data: if (rvalid_i) state_n = e_resp;
      e_resp:    if (io_resp_ready_and_i) state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= e_idle;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (cmd_load_o)
      begin
        aw_done_r <= 1'b0;
        w_done_r  <= 1'b0;
      end
      else
      begin
        if (aw_hs) aw_done_r <= 1'b1;  // AW and W may finish in either order
        if (w_hs) w_done_r <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* bp_axil_lite_top.sv */
// Two-channel bridge from uncached BedRock I/O messages to AXI4-Lite masters
// Channel 0 carries instruction fetch, channel 1 carries data
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module bp_axil_lite_top
  (input  wire                                        clk_i
  ,input  wire                                        arst_n_i

  ,input  wire bp_bedrock_pkg::bp_mem_header_s [1:0]  io_cmd_header_i
  ,input  wire logic [1:0][`BP_AXIL_DATA_W-1:0]       io_cmd_data_i
  ,input  wire logic [1:0]                            io_cmd_v_i
  ,output logic [1:0]                                 io_cmd_ready_and_o

  ,output bp_bedrock_pkg::bp_mem_header_s [1:0]       io_resp_header_o
  ,output logic [1:0][`BP_AXIL_DATA_W-1:0]            io_resp_data_o
  ,output logic [1:0]                                 io_resp_v_o
  ,input  wire logic [1:0]                            io_resp_ready_and_i

  ,output bp_axil_pkg::axil_aw_s [1:0]                m_axil_aw_o
  ,output logic [1:0]                                 m_axil_awvalid_o
  ,input  wire logic [1:0]                            m_axil_awready_i
  ,output bp_axil_pkg::axil_w_s [1:0]                 m_axil_w_o
  ,output logic [1:0]                                 m_axil_wvalid_o
  ,input  wire logic [1:0]                            m_axil_wready_i
  ,input  wire logic [1:0][`BP_AXIL_RESP_W-1:0]       m_axil_bresp_i  // Error codes are not acted on
  ,input  wire logic [1:0]                            m_axil_bvalid_i
  ,output logic [1:0]                                 m_axil_bready_o
  ,output bp_axil_pkg::axil_ar_s [1:0]                m_axil_ar_o
  ,output logic [1:0]                                 m_axil_arvalid_o
  ,input  wire logic [1:0]                            m_axil_arready_i
  ,input  wire bp_axil_pkg::axil_r_s [1:0]            m_axil_r_i
  ,input  wire logic [1:0]                            m_axil_rvalid_i
  ,output logic [1:0]                                 m_axil_rready_o
  );

  logic [1:0]                      cmd_load;
  logic [1:0]                      rdata_load;
  logic [1:0][`BP_AXIL_DATA_W-1:0] rd_data;

  for (genvar i = 0; i < 2; i++)
  begin : chan_g
    bp_axil_ctrl ctrl_i
      (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.io_cmd_v_i(io_cmd_v_i[i]), .io_cmd_ready_and_o(io_cmd_ready_and_o[i])
      ,.cmd_type_i(io_cmd_header_i[i].msg_type)
      ,.awvalid_o(m_axil_awvalid_o[i]), .awready_i(m_axil_awready_i[i])
      ,.wvalid_o(m_axil_wvalid_o[i]), .wready_i(m_axil_wready_i[i])
      ,.bvalid_i(m_axil_bvalid_i[i]), .bready_o(m_axil_bready_o[i])
      ,.arvalid_o(m_axil_arvalid_o[i]), .arready_i(m_axil_arready_i[i])
      ,.rvalid_i(m_axil_rvalid_i[i]), .rready_o(m_axil_rready_o[i])
      ,.io_resp_v_o(io_resp_v_o[i]), .io_resp_ready_and_i(io_resp_ready_and_i[i])
      ,.cmd_load_o(cmd_load[i]), .rdata_load_o(rdata_load[i])
      );

    bp_axil_wr_path #(.channel_p(i)) wr_path_i
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_load_i(cmd_load[i])
      ,.cmd_header_i(io_cmd_header_i[i]), .cmd_data_i(io_cmd_data_i[i])
      ,.aw_o(m_axil_aw_o[i]), .w_o(m_axil_w_o[i])
      );

    bp_axil_rd_path #(.channel_p(i)) rd_path_i
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_load_i(cmd_load[i])
      ,.cmd_header_i(io_cmd_header_i[i]), .rdata_load_i(rdata_load[i])
      ,.r_i(m_axil_r_i[i]), .ar_o(m_axil_ar_o[i]), .rd_data_o(rd_data[i])
      );

    bp_axil_resp_path resp_path_i
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_load_i(cmd_load[i])
      ,.cmd_header_i(io_cmd_header_i[i]), .rd_data_i(rd_data[i])
      ,.io_resp_header_o(io_resp_header_o[i]), .io_resp_data_o(io_resp_data_o[i])
      );
  end

endmodule

`default_nettype wire

/* bp_axil_pkg.sv */
// AXI4-Lite channel payloads
// Valid and ready stay as separate scalar ports
`default_nettype none

`include "bp_axil_consts.svh"

package bp_axil_pkg;

  // Write address channel
  typedef struct packed
  {
    logic [`BP_AXIL_ADDR_W-1:0] addr;
    logic [`BP_AXIL_PROT_W-1:0] prot;
  } axil_aw_s;

  // Read address channel
  typedef struct packed
  {
    logic [`BP_AXIL_ADDR_W-1:0] addr;
    logic [`BP_AXIL_PROT_W-1:0] prot;
  } axil_ar_s;

  // Write data channel
  typedef struct packed
  {
    logic [`BP_AXIL_DATA_W-1:0] data;
    logic [`BP_AXIL_STRB_W-1:0] strb;
  } axil_w_s;

  // Read data channel
  typedef struct packed
  {
    logic [`BP_AXIL_DATA_W-1:0] data;
    logic [`BP_AXIL_RESP_W-1:0] resp;
  } axil_r_s;

endpackage

`default_nettype wire

/* bp_axil_rd_path.sv */
// Read path: AR payload and sub-word extraction of the returned data
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module bp_axil_rd_path
  #(parameter int channel_p = 0)
  (input  wire                                   clk_i
  ,input  wire                                   arst_n_i
  ,input  wire                                   cmd_load_i
  ,input  wire bp_bedrock_pkg::bp_mem_header_s   cmd_header_i
  ,input  wire                                   rdata_load_i
  ,input  wire bp_axil_pkg::axil_r_s             r_i
  ,output bp_axil_pkg::axil_ar_s                 ar_o
  ,output logic [`BP_AXIL_DATA_W-1:0]            rd_data_o
  );

  import bp_bedrock_pkg::*;

  // Same protection code as the write path of this channel
  localparam logic [`BP_AXIL_PROT_W-1:0] prot_lp = '0;

  bp_msg_size_e               size_r;
  logic [`BP_AXIL_OFFS_W-1:0] offs_r;
  logic [`BP_AXIL_DATA_W-1:0] rdata_shift;
  logic [`BP_AXIL_DATA_W-1:0] rdata_mask;

  assign rdata_shift = r_i.data >> {offs_r, 3'b000};  // Bring addressed lane to byte 0

  always_comb
  begin
    case (size_r)
      e_size_1: rdata_mask = 64'h0000_0000_0000_00ff;
      e_size_2: rdata_mask = 64'h0000_0000_0000_ffff;
      e_size_4: rdata_mask = 64'h0000_0000_ffff_ffff;
      default:  rdata_mask = 64'hffff_ffff_ffff_ffff;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ar_o      <= '0;
      size_r    <= e_size_1;
      offs_r    <= '0;
      rd_data_o <= '0;
    end
    else
    begin
      if (cmd_load_i)
      begin
        ar_o.addr <= cmd_header_i.addr;
        ar_o.prot <= prot_lp;
        size_r    <= cmd_header_i.size;
        offs_r    <= cmd_header_i.addr[`BP_AXIL_OFFS_W-1:0];
      end
      if (rdata_load_i) rd_data_o <= rdata_shift & rdata_mask;  // Zero-extended
    end
  end

endmodule

`default_nettype wire

/* bp_axil_resp_path.sv */
// Response payload holder: echoed header and read data or zero
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module bp_axil_resp_path
  (input  wire                                   clk_i
  ,input  wire                                   arst_n_i
  ,input  wire                                   cmd_load_i
  ,input  wire bp_bedrock_pkg::bp_mem_header_s   cmd_header_i
  ,input  wire logic [`BP_AXIL_DATA_W-1:0]       rd_data_i
  ,output bp_bedrock_pkg::bp_mem_header_s        io_resp_header_o
  ,output logic [`BP_AXIL_DATA_W-1:0]            io_resp_data_o
  );

  import bp_bedrock_pkg::*;

  bp_mem_header_s hdr_r;

  // Header is captured at acceptance and kept until the next command
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hdr_r <= '0;
    end
    else if (cmd_load_i)
    begin
      hdr_r <= cmd_header_i;
    end
  end

  assign io_resp_header_o = hdr_r;

  // Read data only changes on the R handshake, so it is stable here too
  assign io_resp_data_o = (hdr_r.msg_type == e_mem_uc_rd) ? rd_data_i : '0;

endmodule

`default_nettype wire

/* bp_axil_wr_path.sv */
// Write payload builder: AW address and W data with byte strobes
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module bp_axil_wr_path
  #(parameter int channel_p = 0)
  (input  wire                                   clk_i
  ,input  wire                                   arst_n_i
  ,input  wire                                   cmd_load_i
  ,input  wire bp_bedrock_pkg::bp_mem_header_s   cmd_header_i
  ,input  wire logic [`BP_AXIL_DATA_W-1:0]       cmd_data_i
  ,output bp_axil_pkg::axil_aw_s                 aw_o
  ,output bp_axil_pkg::axil_w_s                  w_o
  );

  import bp_bedrock_pkg::*;

  // Unprivileged, secure, data-class access on both fetch and data channels
  localparam logic [`BP_AXIL_PROT_W-1:0] prot_lp = '0;

  logic [`BP_AXIL_DATA_W-1:0] wdata_rep;
  logic [`BP_AXIL_STRB_W-1:0] size_mask;
  logic [`BP_AXIL_OFFS_W-1:0] lane_offs;

  assign lane_offs = cmd_header_i.addr[`BP_AXIL_OFFS_W-1:0];

  always_comb
  begin
    case (cmd_header_i.size)
      e_size_1:
      begin
        wdata_rep = {8{cmd_data_i[7:0]}};
        size_mask = 8'h01;
      end
      e_size_2:
      begin
        wdata_rep = {4{cmd_data_i[15:0]}};
        size_mask = 8'h03;
      end
      e_size_4:
      begin
        wdata_rep = {2{cmd_data_i[31:0]}};
        size_mask = 8'h0f;
      end
      default:
      begin
        wdata_rep = cmd_data_i;
        size_mask = 8'hff;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      aw_o <= '0;
      w_o  <= '0;
    end
    else if (cmd_load_i)
    begin
      aw_o.addr <= cmd_header_i.addr;
      aw_o.prot <= prot_lp;
      w_o.data  <= wdata_rep;
      w_o.strb  <= size_mask << lane_offs;  // Aligned, so never wraps past lane 7
    end
  end

endmodule

`default_nettype wire

/* bp_bedrock_pkg.sv */
// BedRock uncached I/O message types
// Opcodes, transfer sizes and the command/response header
`default_nettype none

`include "bp_axil_consts.svh"

package bp_bedrock_pkg;

  // Uncached memory opcodes
  typedef enum logic [`BP_MSG_TYPE_W-1:0]
  {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } bp_msg_type_e;

  // Transfer size is 2^size bytes
  typedef enum logic [`BP_MSG_SIZE_W-1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } bp_msg_size_e;

  // Same header travels on the command and the response port
  typedef struct packed
  {
    bp_msg_type_e                msg_type;
    bp_msg_size_e                size;
    logic [`BP_AXIL_ADDR_W-1:0]  addr;
    logic [`BP_MSG_TAG_W-1:0]    tag;  // Opaque to the bridge, echoed back
  } bp_mem_header_s;

endpackage

`default_nettype wire

/* list.f */
+incdir+.
bp_bedrock_pkg.sv
bp_axil_pkg.sv
bp_axil_ctrl.sv
bp_axil_wr_path.sv
bp_axil_rd_path.sv
bp_axil_resp_path.sv
bp_axil_lite_top.sv
tb_axil_mem.sv
tb_bp_axil_lite_top.sv

/* tb_axil_mem.sv */
// AXI4-Lite slave memory for the bridge testbench
// 256 words of 64 bits with byte strobes and a random wait of 0 to 3 cycles per phase
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module tb_axil_mem
  (input  wire                          clk_i
  ,input  wire                          arst_n_i
  ,input  wire logic [1:0]              dly_i  // Next wait, taken after every phase
  ,input  wire bp_axil_pkg::axil_aw_s   aw_i
  ,input  wire                          awvalid_i
  ,output logic                         awready_o
  ,input  wire bp_axil_pkg::axil_w_s    w_i
  ,input  wire                          wvalid_i
  ,output logic                         wready_o
  ,output logic [`BP_AXIL_RESP_W-1:0]   bresp_o
  ,output logic                         bvalid_o
  ,input  wire                          bready_i
  ,input  wire bp_axil_pkg::axil_ar_s   ar_i
  ,input  wire                          arvalid_i
  ,output logic                         arready_o
  ,output bp_axil_pkg::axil_r_s         r_o
  ,output logic                         rvalid_o
  ,input  wire                          rready_i
  ,output logic [`BP_AXIL_ADDR_W-1:0]   last_addr_o
  );

  import bp_axil_pkg::*;

  logic [`BP_AXIL_DATA_W-1:0] mem_r [256];
  axil_w_s                    w_r;
  logic [7:0]                 waddr_r;
  logic [7:0]                 raddr_r;
  logic [1:0]                 wait_r;
  logic                       aw_seen_r;
  logic                       w_seen_r;
  logic                       rd_pend_r;
  logic                       wr_commit;
  logic                       rd_fire;

  // A ready is only raised with its valid, so each ready marks a handshake
  assign awready_o = awvalid_i & ~aw_seen_r & (wait_r == 2'd0);
  assign wready_o  = wvalid_i & ~w_seen_r & (wait_r == 2'd0);
  assign arready_o = arvalid_i & ~rd_pend_r & ~rvalid_o & (wait_r == 2'd0);
  assign wr_commit = aw_seen_r & w_seen_r & ~bvalid_o & (wait_r == 2'd0);
  assign rd_fire   = rd_pend_r & (wait_r == 2'd0);
  assign bresp_o   = '0;

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem_r[i] = {8{i[7:0]}} ^ 64'h0f1e_2d3c_4b5a_6978;  // Every byte carries the word index
  end

  always @(posedge clk_i)
  begin
    if (wr_commit)
    begin
      for (int b = 0; b < `BP_AXIL_STRB_W; b++)
        if (w_r.strb[b]) mem_r[waddr_r][8*b +: 8] <= w_r.data[8*b +: 8];
    end
  end

  always @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wait_r      <= 2'd0;
      aw_seen_r   <= 1'b0;
      w_seen_r    <= 1'b0;
      rd_pend_r   <= 1'b0;
      bvalid_o    <= 1'b0;
      rvalid_o    <= 1'b0;
      w_r         <= '0;
      r_o         <= '0;
      waddr_r     <= '0;
      raddr_r     <= '0;
      last_addr_o <= '0;
    end
    else
    begin
      if (awready_o | wready_o | arready_o | wr_commit | rd_fire) wait_r <= dly_i;
      else if (wait_r != 2'd0) wait_r <= wait_r - 2'd1;
      if (awready_o)
      begin
        aw_seen_r   <= 1'b1;
        waddr_r     <= aw_i.addr[10:3];
        last_addr_o <= aw_i.addr;
      end
      if (wready_o)
      begin
        w_seen_r <= 1'b1;
        w_r      <= w_i;
      end
      if (wr_commit)
      begin
        aw_seen_r <= 1'b0;
        w_seen_r  <= 1'b0;
        bvalid_o  <= 1'b1;
      end
      else if (bready_i) bvalid_o <= 1'b0;
      if (arready_o)
      begin
        rd_pend_r   <= 1'b1;
        raddr_r     <= ar_i.addr[10:3];
        last_addr_o <= ar_i.addr;
      end
      if (rd_fire)
      begin
        rd_pend_r <= 1'b0;
        rvalid_o  <= 1'b1;
        r_o.data  <= mem_r[raddr_r];
        r_o.resp  <= '0;
      end
      else if (rready_i) rvalid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* tb_bp_axil_lite_top.sv */
// Testbench for the two-channel message to AXI4-Lite bridge
// Directed tests against one slave memory per channel with random wait states
`timescale 1ns/10ps
`default_nettype none

`include "bp_axil_consts.svh"

module tb_bp_axil_lite_top;

  import bp_bedrock_pkg::*;
  import bp_axil_pkg::*;

  localparam int cmd_count_lp = 100;  // Commands issued by all tests together
  localparam int worst_lat_lp = 40;   // Every wait at its maximum plus the longest stall
  localparam int timeout_lp   = cmd_count_lp * worst_lat_lp * 5;

  logic                            clk_i = 1'b0;
  logic                            arst_n_i;
  bp_mem_header_s [1:0]            cmd_header;
  logic [1:0][`BP_AXIL_DATA_W-1:0] cmd_data;
  logic [1:0]                      cmd_v;
  logic [1:0]                      cmd_ready;
  bp_mem_header_s [1:0]            resp_header;
  logic [1:0][`BP_AXIL_DATA_W-1:0] resp_data;
  logic [1:0]                      resp_v;
  logic [1:0]                      resp_ready;
  axil_aw_s [1:0]                  aw;
  axil_w_s [1:0]                   w;
  axil_ar_s [1:0]                  ar;
  axil_r_s [1:0]                   r;
  logic [1:0][`BP_AXIL_RESP_W-1:0] bresp;
  logic [1:0]                      awvalid;
  logic [1:0]                      awready;
  logic [1:0]                      wvalid;
  logic [1:0]                      wready;
  logic [1:0]                      bvalid;
  logic [1:0]                      bready;
  logic [1:0]                      arvalid;
  logic [1:0]                      arready;
  logic [1:0]                      rvalid;
  logic [1:0]                      rready;
  logic [1:0][`BP_AXIL_ADDR_W-1:0] last_addr;
  logic [1:0][1:0]                 dly = '0;
  logic [31:0]                     dly_seed = 32'd37;
  logic [31:0]                     data_seed = 32'd37;

  bp_axil_lite_top dut_i
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
    ,.io_cmd_header_i(cmd_header), .io_cmd_data_i(cmd_data)
    ,.io_cmd_v_i(cmd_v), .io_cmd_ready_and_o(cmd_ready)
    ,.io_resp_header_o(resp_header), .io_resp_data_o(resp_data)
    ,.io_resp_v_o(resp_v), .io_resp_ready_and_i(resp_ready)
    ,.m_axil_aw_o(aw), .m_axil_awvalid_o(awvalid), .m_axil_awready_i(awready)
    ,.m_axil_w_o(w), .m_axil_wvalid_o(wvalid), .m_axil_wready_i(wready)
    ,.m_axil_bresp_i(bresp), .m_axil_bvalid_i(bvalid), .m_axil_bready_o(bready)
    ,.m_axil_ar_o(ar), .m_axil_arvalid_o(arvalid), .m_axil_arready_i(arready)
    ,.m_axil_r_i(r), .m_axil_rvalid_i(rvalid), .m_axil_rready_o(rready)
    );

  for (genvar i = 0; i < 2; i++)
  begin : mem_g
    tb_axil_mem mem_i
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .dly_i(dly[i])
      ,.aw_i(aw[i]), .awvalid_i(awvalid[i]), .awready_o(awready[i])
      ,.w_i(w[i]), .wvalid_i(wvalid[i]), .wready_o(wready[i])
      ,.bresp_o(bresp[i]), .bvalid_o(bvalid[i]), .bready_i(bready[i])
      ,.ar_i(ar[i]), .arvalid_i(arvalid[i]), .arready_o(arready[i])
      ,.r_o(r[i]), .rvalid_o(rvalid[i]), .rready_i(rready[i])
      ,.last_addr_o(last_addr[i])
      );
  end

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits have the longest period
  always @(posedge clk_i)
  begin
    dly_seed <= lcg_step(dly_seed);
    dly      <= {dly_seed[31:30], dly_seed[29:28]};
  end

  task automatic next_rand(output logic [31:0] value);
    data_seed = lcg_step(data_seed);
    value = data_seed;
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch");
    end
  endtask

  // Both channels offer protection code zero with every AXI address
  always @(negedge clk_i)
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (awvalid[i]) check_equal(64'(aw[i].prot), 64'd0, "AW protection code");
      if (arvalid[i]) check_equal(64'(ar[i].prot), 64'd0, "AR protection code");
    end
  end

  // Lane b takes byte (b mod 2^size) of the command data when its strobe is set
  function automatic logic [63:0] merge_write(input logic [63:0] old, input logic [63:0] data,
                                              input int size, input int offs);
    logic [63:0] res;
    int          n;
    res = old;
    n = 1 << size;
    for (int b = 0; b < 8; b++)
      if (b >= offs && b < offs + n) res[8*b +: 8] = data[8*(b % n) +: 8];
    return res;
  endfunction

  function automatic logic [63:0] extract_read(input logic [63:0] word, input int size,
                                               input int offs);
    logic [63:0] res;
    res = '0;
    for (int b = 0; b < (1 << size); b++)
      res[8*b +: 8] = word[8*(offs + b) +: 8];
    return res;
  endfunction

  task automatic send_cmd(input int ch, input bp_mem_header_s hdr, input logic [63:0] data);
    @(posedge clk_i);
    cmd_header[ch] <= hdr;
    cmd_data[ch]   <= data;
    cmd_v[ch]      <= 1'b1;
    @(negedge clk_i);
    while (!cmd_ready[ch]) @(negedge clk_i);
    @(posedge clk_i);  // Command transfers on this edge
    cmd_v[ch] <= 1'b0;
  endtask

  task automatic get_resp(input int ch, input bp_mem_header_s hdr, output logic [63:0] data);
    @(negedge clk_i);
    while (!resp_v[ch]) @(negedge clk_i);
    check_equal(64'(resp_header[ch]), 64'(hdr), "response header");
    data = resp_data[ch];
    @(posedge clk_i);
  endtask

  task automatic do_cmd(input int ch, input logic wr, input logic [1:0] size,
                        input logic [31:0] addr, input logic [7:0] tag,
                        input logic [63:0] wdata, output logic [63:0] rdata);
    bp_mem_header_s hdr;
    hdr.msg_type = wr ? e_mem_uc_wr : e_mem_uc_rd;
    hdr.size     = bp_msg_size_e'(size);
    hdr.addr     = addr;
    hdr.tag      = tag;
    send_cmd(ch, hdr, wdata);
    get_resp(ch, hdr, rdata);
    check_equal(64'(last_addr[ch]), 64'(addr), "AXI address");
    if (wr) check_equal(rdata, '0, "write response data");
  endtask

  task automatic word_roundtrip();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [63:0] got;
    for (int ch = 0; ch < 2; ch++)
    begin
      next_rand(r0);
      next_rand(r1);
      next_rand(r2);
      do_cmd(ch, 1'b1, 2'd3, r2 & 32'hffff_fff8, r2[7:0], {r0, r1}, got);
      do_cmd(ch, 1'b0, 2'd3, r2 & 32'hffff_fff8, r2[15:8], '0, got);
      check_equal(got, {r0, r1}, "8-byte read back");
    end
  endtask

  task automatic merge_sub_writes();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [63:0] word;
    logic [63:0] got;
    for (int ch = 0; ch < 2; ch++)
    begin
      next_rand(r0);
      next_rand(r1);
      word = {r0, r1};
      do_cmd(ch, 1'b1, 2'd3, 32'h100, r0[7:0], word, got);
      for (int s = 0; s < 3; s++)
        for (int offs = 0; offs < 8; offs += (1 << s))
        begin
          next_rand(r0);
          next_rand(r1);
          do_cmd(ch, 1'b1, 2'(s), 32'h100 + 32'(offs), r1[7:0], {r0, r1}, got);
          word = merge_write(word, {r0, r1}, s, offs);
          do_cmd(ch, 1'b0, 2'd3, 32'h100, r1[15:8], '0, got);
          check_equal(got, word, "merged word");
        end
    end
  endtask

  task automatic read_sub_words();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [63:0] got;
    for (int ch = 0; ch < 2; ch++)
    begin
      next_rand(r0);
      next_rand(r1);
      do_cmd(ch, 1'b1, 2'd3, 32'h200, r0[7:0], {r0, r1}, got);
      for (int s = 0; s < 4; s++)
        for (int offs = 0; offs < 8; offs += (1 << s))
        begin
          do_cmd(ch, 1'b0, 2'(s), 32'h200 + 32'(offs), 8'(offs), '0, got);
          check_equal(got, extract_read({r0, r1}, s, offs), "sub-word read");
        end
    end
  endtask

  task automatic hold_under_backpressure();
    logic [31:0]    rnd;
    logic [63:0]    held_data;
    bp_mem_header_s hdr;
    int             stall;
    for (int ch = 0; ch < 2; ch++)
    begin
      next_rand(rnd);
      stall        = 1 + int'(rnd[31:29]);
      hdr.msg_type = e_mem_uc_rd;
      hdr.size     = e_size_8;
      hdr.addr     = 32'h100;
      hdr.tag      = rnd[7:0];
      @(posedge clk_i);
      resp_ready[ch] <= 1'b0;
      send_cmd(ch, hdr, '0);
      @(negedge clk_i);
      while (!resp_v[ch]) @(negedge clk_i);
      held_data = resp_data[ch];
      repeat (stall)
      begin
        @(negedge clk_i);
        check_equal(64'(resp_v[ch]), 64'd1, "held response valid");
        check_equal(64'(cmd_ready[ch]), 64'd0, "command ready while response held");
        check_equal(64'(resp_header[ch]), 64'(hdr), "held response header");
        check_equal(resp_data[ch], held_data, "held response data");
      end
      @(posedge clk_i);
      resp_ready[ch] <= 1'b1;
      @(negedge clk_i);
      check_equal(64'(resp_v[ch]), 64'd1, "response valid at release");
      @(negedge clk_i);
      check_equal(64'(resp_v[ch]), 64'd0, "response valid after one transfer");
      check_equal(64'(cmd_ready[ch]), 64'd1, "command ready after transfer");
    end
  endtask

  task automatic run_both_channels();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [63:0] got0;
    logic [63:0] got1;
    next_rand(r0);
    next_rand(r1);
    next_rand(r2);
    next_rand(r3);
    fork
      begin
        do_cmd(0, 1'b1, 2'd3, 32'h8000_0348, r0[7:0], {r0, r1}, got0);
        do_cmd(0, 1'b0, 2'd3, 32'h8000_0348, r0[15:8], '0, got0);
      end
      begin
        do_cmd(1, 1'b1, 2'd3, 32'h8000_0348, r2[7:0], {r2, r3}, got1);
        do_cmd(1, 1'b0, 2'd3, 32'h8000_0348, r2[15:8], '0, got1);
      end
    join
    check_equal(got0, {r0, r1}, "channel 0 data");
    check_equal(got1, {r2, r3}, "channel 1 data");
  endtask

  initial
  begin
    arst_n_i   = 1'b0;
    cmd_header = '0;
    cmd_data   = '0;
    cmd_v      = '0;
    resp_ready = '0;
    repeat (10) @(posedge clk_i);
    arst_n_i   <= 1'b1;
    resp_ready <= 2'b11;
    @(negedge clk_i);
    // Only the two command readies are high out of reset
    check_equal(64'({cmd_ready, resp_v, awvalid, wvalid, bready, arvalid, rready}), 64'h3000,
                "handshake outputs after reset");
    word_roundtrip();
    merge_sub_writes();
    read_sub_words();
    hold_under_backpressure();
    run_both_channels();
    $display("Test passed");
    $finish;
  end

  initial
  begin
    repeat (timeout_lp) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d clock cycles", timeout_lp);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire
